//--- rtl/dvi_timing_config.svh
`ifndef DVI_TIMING_CONFIG_SVH
`define DVI_TIMING_CONFIG_SVH

////////////////////////////////
// Widths
////////////////////////////////
`define DVI_CNT_W            11 // H/V counters and compare points
`define DVI_COLOR_W          8  // One colour component
`define DVI_DEBOUNCE_CYCLES  64 // Stable cycles before a switch is taken

////////////////////////////////
// Per-mode timing in pixels and lines
////////////////////////////////
// 640x480@60 with negative sync
`define DVI_VGA_HPIXELS      640
`define DVI_VGA_HFNPRCH      16
`define DVI_VGA_HSYNCPW      96
`define DVI_VGA_HBKPRCH      48
`define DVI_VGA_VLINES       480
`define DVI_VGA_VFNPRCH      10
`define DVI_VGA_VSYNCPW      2
`define DVI_VGA_VBKPRCH      33

// 800x600@60
`define DVI_SVGA_HPIXELS     800
`define DVI_SVGA_HFNPRCH     40
`define DVI_SVGA_HSYNCPW     128
`define DVI_SVGA_HBKPRCH     88
`define DVI_SVGA_VLINES      600
`define DVI_SVGA_VFNPRCH     1
`define DVI_SVGA_VSYNCPW     4
`define DVI_SVGA_VBKPRCH     23

// 1024x768@60 with negative sync
`define DVI_XGA_HPIXELS      1024
`define DVI_XGA_HFNPRCH      24
`define DVI_XGA_HSYNCPW      136
`define DVI_XGA_HBKPRCH      160
`define DVI_XGA_VLINES       768
`define DVI_XGA_VFNPRCH      3
`define DVI_XGA_VSYNCPW      6
`define DVI_XGA_VBKPRCH      29

// 1280x720@60 and the fallback for unknown codes
`define DVI_720P_HPIXELS     1280
`define DVI_720P_HFNPRCH     110
`define DVI_720P_HSYNCPW     40
`define DVI_720P_HBKPRCH     220
`define DVI_720P_VLINES      720
`define DVI_720P_VFNPRCH     5
`define DVI_720P_VSYNCPW     5
`define DVI_720P_VBKPRCH     20

// 1280x1024@60
`define DVI_SXGA_HPIXELS     1280
`define DVI_SXGA_HFNPRCH     48
`define DVI_SXGA_HSYNCPW     112
`define DVI_SXGA_HBKPRCH     248
`define DVI_SXGA_VLINES      1024
`define DVI_SXGA_VFNPRCH     1
`define DVI_SXGA_VSYNCPW     3
`define DVI_SXGA_VBKPRCH     38

// Camera source with 720 lines and odd porches
`define DVI_CAMERA_HPIXELS   1280
`define DVI_CAMERA_HFNPRCH   110
`define DVI_CAMERA_HSYNCPW   39
`define DVI_CAMERA_HBKPRCH   220
`define DVI_CAMERA_VLINES    720
`define DVI_CAMERA_VFNPRCH   4
`define DVI_CAMERA_VSYNCPW   4
`define DVI_CAMERA_VBKPRCH   22

`endif

//--- rtl/dvi_timing_pkg.sv
`include "dvi_timing_config.svh"

package dvi_timing_pkg;

	////////////////////////////////
	// Switch codes
	////////////////////////////////
	typedef enum logic [3:0] {
		VGA      = 4'b0000,
		SVGA     = 4'b0001,
		HDTV720P = 4'b0010,
		XGA      = 4'b0011,
		SXGA     = 4'b1000,
		CAMERA   = 4'b1001
	} mode_e;

	////////////////////////////////
	// Compare points for one mode
	////////////////////////////////
	// Horizontal points run off the pixel count, vertical off the line count
	typedef struct packed {
		logic [`DVI_CNT_W-1:0] hsblnk; // Last live pixel
		logic [`DVI_CNT_W-1:0] hssync; // Last pixel before hsync
		logic [`DVI_CNT_W-1:0] hesync; // Last hsync pixel
		logic [`DVI_CNT_W-1:0] heblnk; // Last pixel of the line
		logic [`DVI_CNT_W-1:0] vsblnk; // Last live line
		logic [`DVI_CNT_W-1:0] vssync; // Last line before vsync
		logic [`DVI_CNT_W-1:0] vesync; // Last vsync line
		logic [`DVI_CNT_W-1:0] veblnk; // Last line of the frame
		logic                  neg_sync; // 1 = sync pulses low
	} timing_t;

	// One pixel, red in the top byte
	typedef struct packed {
		logic [`DVI_COLOR_W-1:0] red;
		logic [`DVI_COLOR_W-1:0] green;
		logic [`DVI_COLOR_W-1:0] blue;
	} pixel_t;

endpackage

//--- rtl/dvi_timing_if.sv
`timescale 1ns/1ps

// Mode record from the selector to the timing generator
interface mode_if;
	dvi_timing_pkg::timing_t timing; // Compare points plus polarity
	logic                    restart; // One cycle, counters back to 0

	modport src (
		output timing,
		output restart
	);

	modport dst (
		input timing,
		input restart
	);
endinterface

// Raster strobes from the timing generator
interface video_if;
	logic active; // Counter inside live area, same cycle
	logic load;   // Last position of the frame
	logic de;     // Data enable, 2 cycles behind the counters
	logic hsync;  // Polarity applied, aligned with de
	logic vsync;

	modport src (
		output active,
		output load,
		output de,
		output hsync,
		output vsync
	);

	modport dst (
		input active,
		input de
	);
endinterface

//--- rtl/switch_debounce.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module switch_debounce #(
	parameter int unsigned CYCLES = `DVI_DEBOUNCE_CYCLES
) (
	input  logic pclk,
	input  logic RSTBTN,
	input  logic sw_async,
	output logic sw_stable
);

	// Holds 0 .. CYCLES-1
	localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES) : 1;

	logic             sync_1; // First flop, may go metastable
	logic             sync_2;
	logic [CNT_W-1:0] hold_cnt; // Cycles the new level has held

	////////////////////////////////
	// Synchroniser
	////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end else begin
			sync_1 <= sw_async;
			sync_2 <= sync_1;
		end
	end

	////////////////////////////////
	// Stability counter
	////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			hold_cnt  <= '0;
			sw_stable <= 1'b0;
		end else if (sync_2 == sw_stable) begin
			hold_cnt <= '0; // Bounce back, start over
		end else if (hold_cnt == CNT_W'(CYCLES - 1)) begin
			hold_cnt  <= '0;
			sw_stable <= sync_2; // Held long enough
		end else begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

//--- rtl/mode_select.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module mode_select (
	input  logic       pclk,
	input  logic       RSTBTN,
	input  logic [3:0] sw_stable,
	mode_if.src        mode
);

	localparam int CW = `DVI_CNT_W;

	logic [3:0] cur_code; // Code the generator runs on

	// Live count minus one, then porches and sync stacked on top
	function automatic dvi_timing_pkg::timing_t calc(
		input int   hpix, hfp, hsw, hbp,
		input int   vlin, vfp, vsw, vbp,
		input logic neg
	);
		dvi_timing_pkg::timing_t t;
		t.hsblnk   = CW'(hpix - 1);
		t.hssync   = CW'(hpix - 1 + hfp);
		t.hesync   = CW'(hpix - 1 + hfp + hsw);
		t.heblnk   = CW'(hpix - 1 + hfp + hsw + hbp);
		t.vsblnk   = CW'(vlin - 1);
		t.vssync   = CW'(vlin - 1 + vfp);
		t.vesync   = CW'(vlin - 1 + vfp + vsw);
		t.veblnk   = CW'(vlin - 1 + vfp + vsw + vbp);
		t.neg_sync = neg;
		return t;
	endfunction

	function automatic dvi_timing_pkg::timing_t lookup(input logic [3:0] code);
		case (code)
			dvi_timing_pkg::VGA: return calc(`DVI_VGA_HPIXELS, `DVI_VGA_HFNPRCH,
				`DVI_VGA_HSYNCPW, `DVI_VGA_HBKPRCH, `DVI_VGA_VLINES,
				`DVI_VGA_VFNPRCH, `DVI_VGA_VSYNCPW, `DVI_VGA_VBKPRCH, 1'b1);
			dvi_timing_pkg::SVGA: return calc(`DVI_SVGA_HPIXELS, `DVI_SVGA_HFNPRCH,
				`DVI_SVGA_HSYNCPW, `DVI_SVGA_HBKPRCH, `DVI_SVGA_VLINES,
				`DVI_SVGA_VFNPRCH, `DVI_SVGA_VSYNCPW, `DVI_SVGA_VBKPRCH, 1'b0);
			dvi_timing_pkg::XGA: return calc(`DVI_XGA_HPIXELS, `DVI_XGA_HFNPRCH,
				`DVI_XGA_HSYNCPW, `DVI_XGA_HBKPRCH, `DVI_XGA_VLINES,
				`DVI_XGA_VFNPRCH, `DVI_XGA_VSYNCPW, `DVI_XGA_VBKPRCH, 1'b1);
			dvi_timing_pkg::SXGA: return calc(`DVI_SXGA_HPIXELS, `DVI_SXGA_HFNPRCH,
				`DVI_SXGA_HSYNCPW, `DVI_SXGA_HBKPRCH, `DVI_SXGA_VLINES,
				`DVI_SXGA_VFNPRCH, `DVI_SXGA_VSYNCPW, `DVI_SXGA_VBKPRCH, 1'b0);
			dvi_timing_pkg::CAMERA: return calc(`DVI_CAMERA_HPIXELS, `DVI_CAMERA_HFNPRCH,
				`DVI_CAMERA_HSYNCPW, `DVI_CAMERA_HBKPRCH, `DVI_CAMERA_VLINES,
				`DVI_CAMERA_VFNPRCH, `DVI_CAMERA_VSYNCPW, `DVI_CAMERA_VBKPRCH, 1'b0);
			default: return calc(`DVI_720P_HPIXELS, `DVI_720P_HFNPRCH, // 720p and unknown
				`DVI_720P_HSYNCPW, `DVI_720P_HBKPRCH, `DVI_720P_VLINES,
				`DVI_720P_VFNPRCH, `DVI_720P_VSYNCPW, `DVI_720P_VBKPRCH, 1'b0);
		endcase
	endfunction

	////////////////////////////////
	// Change detect and record load
	////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			cur_code     <= dvi_timing_pkg::VGA;
			mode.timing  <= lookup(dvi_timing_pkg::VGA);
			mode.restart <= 1'b0;
		end else begin
			mode.restart <= (sw_stable != cur_code); // Every change, also unknown to unknown
			if (sw_stable != cur_code) begin
				cur_code    <= sw_stable;
				mode.timing <= lookup(sw_stable);
			end
		end
	end

endmodule

//--- rtl/video_timing.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module video_timing (
	input logic pclk,
	input logic RSTBTN,
	mode_if.dst mode,
	video_if.src video
);

	logic [`DVI_CNT_W-1:0] hcount; // Pixel within line
	logic [`DVI_CNT_W-1:0] vcount; // Line within frame
	logic                  running; // Low until one cycle after reset
	logic                  line_end;
	logic                  frame_end;
	logic                  active;
	logic                  hsync_int; // High-true sync from the counters
	logic                  vsync_int;
	logic                  hsync_q; // Stage 1, polarity applied
	logic                  vsync_q;
	logic                  active_q;

	////////////////////////////////
	// Counters
	////////////////////////////////
	assign line_end  = (hcount == mode.timing.heblnk);
	assign frame_end = line_end && (vcount == mode.timing.veblnk);

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			running <= 1'b0;
			hcount  <= '0;
			vcount  <= '0;
		end else begin
			running <= 1'b1;
			if (mode.restart) begin // New mode, start a fresh line
				hcount <= '0;
				vcount <= '0;
			end else if (running) begin
				if (line_end) begin
					hcount <= '0;
					vcount <= frame_end ? '0 : vcount + 1'b1;
				end else begin
					hcount <= hcount + 1'b1;
				end
			end
		end
	end

	////////////////////////////////
	// Decode, same cycle as counters
	////////////////////////////////
	assign active = running
		&& (hcount <= mode.timing.hsblnk)
		&& (vcount <= mode.timing.vsblnk);
	assign hsync_int = (hcount > mode.timing.hssync) && (hcount <= mode.timing.hesync);
	assign vsync_int = (vcount > mode.timing.vssync) && (vcount <= mode.timing.vesync);

	assign video.active = active; // Also the stream ready
	assign video.load   = frame_end;

	////////////////////////////////
	// Two-stage output pipeline
	////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			hsync_q     <= 1'b1; // Idle level of VGA
			vsync_q     <= 1'b1;
			active_q    <= 1'b0;
			video.hsync <= 1'b1;
			video.vsync <= 1'b1;
			video.de    <= 1'b0;
		end else begin
			hsync_q     <= hsync_int ^ mode.timing.neg_sync;
			vsync_q     <= vsync_int ^ mode.timing.neg_sync;
			active_q    <= active;
			video.hsync <= hsync_q;
			video.vsync <= vsync_q;
			video.de    <= active_q;
		end
	end

endmodule

//--- rtl/pixel_path.sv
`timescale 1ns/1ps

module pixel_path (
	input  logic                   pclk,
	input  logic                   RSTBTN,
	video_if.dst                   video,
	input  dvi_timing_pkg::pixel_t pix_data,
	input  logic                   pix_valid,
	output logic                   pix_ready,
	output dvi_timing_pkg::pixel_t pixel,
	output logic                   underrun
);

	dvi_timing_pkg::pixel_t pix_d1; // Lines up with stage 1 of the syncs
	dvi_timing_pkg::pixel_t pix_d2; // Lines up with de
	logic                   accept;

	// Ready on every live position, valid or not
	assign pix_ready = video.active;
	assign accept    = pix_ready && pix_valid;

	////////////////////////////////
	// Pixel delay
	////////////////////////////////
	always_ff @(posedge pclk) begin
		pix_d1 <= accept ? pix_data : '0; // Missing pixel goes out black
		pix_d2 <= pix_d1;
	end

	assign pixel = video.de ? pix_d2 : '0; // Blank outside live area

	////////////////////////////////
	// Sticky underrun
	////////////////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			underrun <= 1'b0;
		end else if (video.active && !pix_valid) begin
			underrun <= 1'b1;
		end
	end

endmodule

//--- rtl/dvi_timing_top.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module dvi_timing_top (
	input  logic                       pclk,
	input  logic                       RSTBTN,
	input  logic [3:0]                 sw,
	input  logic [3*`DVI_COLOR_W-1:0]  pix_data, // Red in the top byte
	input  logic                       pix_valid,
	output logic                       pix_ready,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       de,
	output logic [`DVI_COLOR_W-1:0]    red,
	output logic [`DVI_COLOR_W-1:0]    green,
	output logic [`DVI_COLOR_W-1:0]    blue,
	output logic                       underrun
);

	logic [3:0]             sw_stable; // Debounced switch code
	dvi_timing_pkg::pixel_t pixel;

	mode_if  mode_bus ();
	video_if video_bus ();

	////////////////////////////////
	// Switch lanes
	////////////////////////////////
	for (genvar i = 0; i < 4; i++) begin : g_sw
		switch_debounce u_deb (
			.pclk      (pclk),
			.RSTBTN    (RSTBTN),
			.sw_async  (sw[i]),
			.sw_stable (sw_stable[i])
		);
	end

	mode_select u_mode (
		.pclk      (pclk),
		.RSTBTN    (RSTBTN),
		.sw_stable (sw_stable),
		.mode      (mode_bus.src)
	);

	video_timing u_timing (
		.pclk   (pclk),
		.RSTBTN (RSTBTN),
		.mode   (mode_bus.dst),
		.video  (video_bus.src)
	);

	pixel_path u_pixel (
		.pclk      (pclk),
		.RSTBTN    (RSTBTN),
		.video     (video_bus.dst),
		.pix_data  (dvi_timing_pkg::pixel_t'(pix_data)),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pixel     (pixel),
		.underrun  (underrun)
	);

	// Outputs, all two cycles behind the counters
	assign hsync = video_bus.hsync;
	assign vsync = video_bus.vsync;
	assign de    = video_bus.de;
	assign red   = pixel.red;
	assign green = pixel.green;
	assign blue  = pixel.blue;

endmodule

//--- testbench/dvi_timing_chk.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module dvi_timing_chk (
	input logic                    pclk,
	input logic                    RSTBTN,
	input logic                    pix_ready,
	input logic                    hsync,
	input logic                    de,
	input logic [`DVI_COLOR_W-1:0] red,
	input logic [`DVI_COLOR_W-1:0] green,
	input logic [`DVI_COLOR_W-1:0] blue,
	input logic                    underrun,
	input logic                    neg_sync // Polarity of the loaded mode
);

	//////////////////////////////
	// Port rules
	//////////////////////////////
	a_ready_in_reset: assert property (@(posedge pclk)
		RSTBTN && $past(RSTBTN) |-> !pix_ready)
		else $error("pix_ready high while reset is held");

	// Blanking carries black only
	a_blank_black: assert property (@(posedge pclk) disable iff (RSTBTN)
		!de |-> (red == '0 && green == '0 && blue == '0))
		else $error("colour output not black outside data enable");

	a_underrun_sticky: assert property (@(posedge pclk) disable iff (RSTBTN)
		underrun |=> underrun)
		else $error("underrun flag dropped without reset");

	// Sync leaves the counters 2 cycles before the port
	a_no_de_in_hsync: assert property (@(posedge pclk) disable iff (RSTBTN)
		de |-> (hsync == $past(neg_sync, 2)))
		else $error("data enable high inside an hsync pulse");

endmodule

//--- testbench/tb_dvi_timing.sv
`timescale 1ns/1ps
`include "dvi_timing_config.svh"

module tb_dvi_timing;

	localparam int DEB       = `DVI_DEBOUNCE_CYCLES;
	localparam int VGA_LINE  = `DVI_VGA_HPIXELS + `DVI_VGA_HFNPRCH + `DVI_VGA_HSYNCPW
		+ `DVI_VGA_HBKPRCH;
	localparam int VGA_FRAME = VGA_LINE * (`DVI_VGA_VLINES + `DVI_VGA_VFNPRCH
		+ `DVI_VGA_VSYNCPW + `DVI_VGA_VBKPRCH);
	localparam int SXGA_LINE = `DVI_SXGA_HPIXELS + `DVI_SXGA_HFNPRCH + `DVI_SXGA_HSYNCPW
		+ `DVI_SXGA_HBKPRCH;
	localparam int RUN_CYCLES = 16 + 2 * VGA_LINE + 2 * VGA_FRAME + 2 * (DEB + 8)
		+ 10 * SXGA_LINE; // Worst case of each test summed
	localparam int LIMIT = RUN_CYCLES + RUN_CYCLES / 10;

	// Expected raster of one mode
	typedef struct packed {
		int h_total;
		int h_sync;
		int h_live;
		int v_total;
		int v_sync;
		int v_live;
		bit neg;
	} mode_ref_t;

	logic        pclk;
	logic        RSTBTN;
	logic [3:0]  sw;
	logic [23:0] pix_data;
	logic        pix_valid;
	wire         pix_ready, hsync, vsync, de, underrun;
	wire  [7:0]  red, green, blue;

	mode_ref_t   ref_tab [16];
	logic [31:0] lfsr = 32'd34;
	logic        gaps = 1'b0; // Random valid gaps on
	logic [24:0] expect_q [$]; // {gap, pixel} per live position
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          pix_checked = 0;
	int          black_checked = 0;
	logic        gap_seen = 1'b0;
	logic        gap_prev = 1'b0;

	dvi_timing_top dut (.*);

	bind dvi_timing_top dvi_timing_chk chk (
		.pclk      (pclk),
		.RSTBTN    (RSTBTN),
		.pix_ready (pix_ready),
		.hsync     (hsync),
		.de        (de),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.underrun  (underrun),
		.neg_sync  (mode_bus.timing.neg_sync)
	);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic mode_ref_t ref_mode(input int hp, hf, hs, hb, vl, vf, vs, vb,
		input bit neg);
		mode_ref_t m;
		m.h_total = hp + hf + hs + hb;
		m.h_sync  = hs;
		m.h_live  = hp;
		m.v_total = vl + vf + vs + vb;
		m.v_sync  = vs;
		m.v_live  = vl;
		m.neg     = neg;
		return m;
	endfunction

	task automatic check_eq(input int got, input int exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors > err_start) tests_failed++;
		$display("test %-12s %s (%0d errors)", name, (errors > err_start) ? "failed" : "ok",
			errors - err_start);
	endtask

	// Next leading edge of hsync with polarity removed
	task automatic wait_lead(input bit neg);
		logic act, act_prev;
		act = 1'b1;
		do begin
			act_prev = act;
			@(negedge pclk);
			act = hsync ^ neg;
		end while (!(act && !act_prev));
	endtask

	task automatic measure_line(input bit neg, output int period, output int width,
		output int de_cnt);
		logic act, act_prev;
		period = 0;
		width  = 0;
		de_cnt = 0;
		wait_lead(neg);
		act = 1'b1;
		do begin
			period++;
			width    += int'(act);
			de_cnt   += int'(de);
			act_prev  = act;
			@(negedge pclk);
			act = hsync ^ neg;
		end while (!(act && !act_prev));
	endtask

	// Lines counted as hsync leading edges between vsync leading edges
	task automatic measure_frame(input bit neg, output int lines, output int sync_lines,
		output int de_lines);
		logic v, v_prev, h, h_prev, d_prev;
		lines      = 0;
		sync_lines = 0;
		de_lines   = 0;
		v = 1'b1;
		do begin
			v_prev = v;
			@(negedge pclk);
			v = vsync ^ neg;
		end while (!(v && !v_prev));
		h_prev = hsync ^ neg;
		d_prev = de;
		do begin
			h = hsync ^ neg;
			if (h && !h_prev) begin
				lines++;
				sync_lines += int'(v);
			end
			if (de && !d_prev) de_lines++;
			h_prev = h;
			d_prev = de;
			v_prev = v;
			@(negedge pclk);
			v = vsync ^ neg;
		end while (!(v && !v_prev));
	endtask

	task automatic check_line(input dvi_timing_pkg::mode_e code);
		int p, w, d;
		measure_line(ref_tab[code].neg, p, w, d);
		check_eq(p, ref_tab[code].h_total, "line period");
		check_eq(w, ref_tab[code].h_sync, "hsync width");
		check_eq(d, ref_tab[code].h_live, "de cycles per line");
	endtask

	task automatic set_mode(input dvi_timing_pkg::mode_e code);
		@(posedge pclk);
		sw <= code;
		repeat (DEB + 8) @(posedge pclk); // Sync, debounce, select, restart
	endtask

	//////////////////////////////
	// Stream source and model
	//////////////////////////////
	always @(posedge pclk) begin
		pix_data  <= 24'(rand_bits(24));
		pix_valid <= gaps ? (rand_bits(4) != 0) : 1'b1; // 15 of 16 when gapped
	end

	always @(negedge pclk) begin
		logic [24:0] e;
		if (!RSTBTN) begin
			if (de) begin // Pixel out 2 cycles after its live position
				if (expect_q.size() == 0) begin
					errors++;
					$display("Data enable high at %0t with no pixel left in the model", $time);
				end else begin
					e = expect_q.pop_front();
					check_eq(int'({red, green, blue}), int'(e[23:0]), "pixel");
					pix_checked++;
					if (e[24]) black_checked++;
				end
			end
			if (pix_ready) expect_q.push_back(pix_valid ? {1'b0, pix_data} : {1'b1, 24'h0});
			if (gap_prev) check_eq(int'(underrun), 1, "underrun after first gap");
			else if (!gap_seen) check_eq(int'(underrun), 0, "underrun before any gap");
			gap_prev = pix_ready && !pix_valid && !gap_seen;
			if (pix_ready && !pix_valid) gap_seen = 1'b1;
		end
	end

	//////////////////////////////
	// Tests
	//////////////////////////////
	initial begin
		int err0, l, s, d;
		RSTBTN    = 1'b1;
		sw        = 4'b0000;
		pix_data  = '0;
		pix_valid = 1'b0;
		ref_tab[dvi_timing_pkg::HDTV720P] = ref_mode(`DVI_720P_HPIXELS, `DVI_720P_HFNPRCH,
			`DVI_720P_HSYNCPW, `DVI_720P_HBKPRCH, `DVI_720P_VLINES, `DVI_720P_VFNPRCH,
			`DVI_720P_VSYNCPW, `DVI_720P_VBKPRCH, 1'b0);
		foreach (ref_tab[i]) ref_tab[i] = ref_tab[dvi_timing_pkg::HDTV720P]; // Unknown codes
		ref_tab[dvi_timing_pkg::VGA] = ref_mode(`DVI_VGA_HPIXELS, `DVI_VGA_HFNPRCH,
			`DVI_VGA_HSYNCPW, `DVI_VGA_HBKPRCH, `DVI_VGA_VLINES, `DVI_VGA_VFNPRCH,
			`DVI_VGA_VSYNCPW, `DVI_VGA_VBKPRCH, 1'b1);
		ref_tab[dvi_timing_pkg::SVGA] = ref_mode(`DVI_SVGA_HPIXELS, `DVI_SVGA_HFNPRCH,
			`DVI_SVGA_HSYNCPW, `DVI_SVGA_HBKPRCH, `DVI_SVGA_VLINES, `DVI_SVGA_VFNPRCH,
			`DVI_SVGA_VSYNCPW, `DVI_SVGA_VBKPRCH, 1'b0);
		ref_tab[dvi_timing_pkg::XGA] = ref_mode(`DVI_XGA_HPIXELS, `DVI_XGA_HFNPRCH,
			`DVI_XGA_HSYNCPW, `DVI_XGA_HBKPRCH, `DVI_XGA_VLINES, `DVI_XGA_VFNPRCH,
			`DVI_XGA_VSYNCPW, `DVI_XGA_VBKPRCH, 1'b1);
		ref_tab[dvi_timing_pkg::SXGA] = ref_mode(`DVI_SXGA_HPIXELS, `DVI_SXGA_HFNPRCH,
			`DVI_SXGA_HSYNCPW, `DVI_SXGA_HBKPRCH, `DVI_SXGA_VLINES, `DVI_SXGA_VFNPRCH,
			`DVI_SXGA_VSYNCPW, `DVI_SXGA_VBKPRCH, 1'b0);
		ref_tab[dvi_timing_pkg::CAMERA] = ref_mode(`DVI_CAMERA_HPIXELS, `DVI_CAMERA_HFNPRCH,
			`DVI_CAMERA_HSYNCPW, `DVI_CAMERA_HBKPRCH, `DVI_CAMERA_VLINES, `DVI_CAMERA_VFNPRCH,
			`DVI_CAMERA_VSYNCPW, `DVI_CAMERA_VBKPRCH, 1'b0);

		err0 = errors;
		repeat (15) begin
			@(negedge pclk);
			check_eq(int'({de, pix_ready, underrun}), 0, "de/ready/underrun in reset");
		end
		@(posedge pclk);
		RSTBTN <= 1'b0; // 16th rising edge
		@(negedge pclk);
		check_eq(int'({de, pix_ready, underrun}), 0, "de/ready/underrun after reset");
		report_test("reset", err0);

		err0 = errors;
		repeat (2) check_line(dvi_timing_pkg::VGA);
		report_test("vga_lines", err0);

		err0 = errors;
		measure_frame(ref_tab[dvi_timing_pkg::VGA].neg, l, s, d);
		check_eq(l, ref_tab[dvi_timing_pkg::VGA].v_total, "lines per frame");
		check_eq(s, ref_tab[dvi_timing_pkg::VGA].v_sync, "vsync lines");
		check_eq(d, ref_tab[dvi_timing_pkg::VGA].v_live, "de lines per frame");
		report_test("vga_frame", err0);

		err0 = errors;
		set_mode(dvi_timing_pkg::HDTV720P);
		check_line(dvi_timing_pkg::HDTV720P);
		set_mode(dvi_timing_pkg::SXGA);
		check_line(dvi_timing_pkg::SXGA);
		fork // Short pulse lands inside the measured line
			measure_line(ref_tab[dvi_timing_pkg::SXGA].neg, l, s, d);
			begin
				wait_lead(ref_tab[dvi_timing_pkg::SXGA].neg);
				@(posedge pclk);
				sw <= dvi_timing_pkg::VGA;
				repeat (DEB / 2) @(posedge pclk);
				sw <= dvi_timing_pkg::SXGA;
			end
		join
		check_eq(l, ref_tab[dvi_timing_pkg::SXGA].h_total, "period across short pulse");
		report_test("mode_change", err0);

		err0 = errors;
		l = pix_checked;
		repeat (2 * ref_tab[dvi_timing_pkg::SXGA].h_total) @(negedge pclk);
		check_eq(int'(pix_checked > l), 1, "pixels compared in no-gap phase");
		report_test("pixel_order", err0);

		err0 = errors;
		gaps = 1'b1;
		wait (gap_seen);
		wait (black_checked > 0); // Black pixel where the gap was
		@(negedge pclk);
		check_eq(int'(underrun), 1, "underrun held");
		report_test("underrun", err0);

		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d pixels compared",
			tests_run, tests_failed, checks, errors, pix_checked);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge pclk);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- dvi_timing.f
+incdir+rtl
rtl/dvi_timing_pkg.sv
rtl/dvi_timing_if.sv
rtl/switch_debounce.sv
rtl/mode_select.sv
rtl/video_timing.sv
rtl/pixel_path.sv
rtl/dvi_timing_top.sv
testbench/dvi_timing_chk.sv
testbench/tb_dvi_timing.sv

//--- Makefile
# Verilator build and run for the DVI timing core

VERILATOR ?= verilator
TOP       ?= tb_dvi_timing
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
FILELIST  := dvi_timing.f
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
